// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vpu_tb
RTL_TOP   ?= vpu_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
src/vpu_msg_pkg.sv
src/vpu_addr_pkg.sv
src/vpu_phase_ctrl.sv
src/vpu_offset_tracker.sv
src/vpu_addr_gen.sv
src/vpu_msg_update.sv
src/vpu_top.sv
tb/vpu_properties.sv
tb/vpu_tb.sv

// ==== src/vpu_addr_gen.sv ====
`timescale 1ns/1ns

module vpu_addr_gen (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                check_start_i,
    input  logic                var_start_i,
    input  logic                check_wr_en_i,
    input  logic                var_wr_en_i,
    input  vpu_addr_pkg::phase_e phase_i,
    input  logic [vpu_msg_pkg::lane_count*vpu_addr_pkg::addr_width-1:0] shift_i,
    input  logic [vpu_addr_pkg::addr_width-1:0]                         bank_offset_i,
    input  logic [vpu_addr_pkg::addr_width-1:0]                         chan_offset_i,
    output logic [vpu_msg_pkg::lane_count*vpu_addr_pkg::addr_width-1:0] bank_addr_o,
    output logic [vpu_addr_pkg::addr_width-1:0]                         chan_addr_o,
    output logic                                                        bank_wr_en_o
);

    import vpu_msg_pkg::*;
    import vpu_addr_pkg::*;

    logic [addr_width-1:0] bank_addr_q [lane_count];
    logic [addr_width-1:0] chan_addr_q;
    logic                  bank_wr_en_q;
    logic                  load_shift;
    logic                  load_offset;
    logic                  sweep;

    // step to the next entry, wrapping at the end of the bank
    function automatic logic [addr_width-1:0] wrap_inc(input logic [addr_width-1:0] a);
        return (a == addr_wrap) ? '0 : a + 1'b1;
    endfunction

    assign load_shift  = check_start_i
                      && (phase_i == phase_armed || phase_i == phase_var_update);
    assign load_offset = var_start_i && (phase_i == phase_check);
    assign sweep       = (phase_i == phase_check) || (phase_i == phase_var_update);

    ////////////////////////////////////////////////////////////////////////////
    // bank address lanes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < lane_count; i++) begin
                bank_addr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                if (load_shift)
                    bank_addr_q[i] <= shift_i[i*addr_width +: addr_width] + bank_offset_i;
                else if (load_offset)
                    bank_addr_q[i] <= bank_offset_i;
                else if (sweep)
                    bank_addr_q[i] <= wrap_inc(bank_addr_q[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            bank_addr_o[i*addr_width +: addr_width] = bank_addr_q[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // channel address and write strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chan_addr_q <= '0;
        end else if (load_offset) begin
            chan_addr_q <= chan_offset_i;
        end else if (phase_i == phase_var_update) begin
            chan_addr_q <= wrap_inc(chan_addr_q);
        end
    end

    // strobe source follows the phase
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bank_wr_en_q <= 1'b0;
        end else begin
            bank_wr_en_q <= (phase_i == phase_check && check_wr_en_i)
                         || (phase_i == phase_var_update && var_wr_en_i);
        end
    end

    assign chan_addr_o  = chan_addr_q;
    assign bank_wr_en_o = bank_wr_en_q;

endmodule

// ==== src/vpu_addr_pkg.sv ====
package vpu_addr_pkg;

    // one 256-entry bank per lane
    localparam int addr_width = 8;

    localparam logic [addr_width-1:0] addr_wrap = 8'd255;

    // offset increments per pass type
    localparam logic [addr_width-1:0] check_step = 8'd5;
    localparam logic [addr_width-1:0] bank_step  = 8'd3;
    localparam logic [addr_width-1:0] chan_step  = 8'd2;

    ////////////////////////////////////////////////////////////////////////////
    // decoder phases, one-hot
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        phase_idle       = 4'b0001,
        phase_armed      = 4'b0010,
        phase_check      = 4'b0100,
        phase_var_update = 4'b1000
    } phase_e;

endpackage

// ==== src/vpu_msg_pkg.sv ====
package vpu_msg_pkg;

    localparam int lane_count        = 3;
    localparam int msg_width_default = 6;

    // largest magnitude a message can carry
    localparam logic [msg_width_default-2:0] sat_mag = '1;

    // one message word, seen as raw bits or as sign and magnitude
    typedef union packed {
        logic [msg_width_default-1:0] raw;
        struct packed {
            logic                         sign;
            logic [msg_width_default-2:0] mag;
        } sm;
    } msg_u;

    // sign-magnitude to two's complement
    function automatic logic signed [msg_width_default-1:0] sm_to_int(input msg_u m);
        logic signed [msg_width_default-1:0] v;
        v = signed'({1'b0, m.sm.mag});
        return m.sm.sign ? -v : v;
    endfunction

    // back to sign-magnitude, clipped at sat_mag
    function automatic msg_u int_to_sat_sm(input logic signed [msg_width_default+1:0] v);
        logic [msg_width_default:0] mag;
        msg_u                       m;
        mag       = v[msg_width_default+1] ? -v[msg_width_default:0] : v[msg_width_default:0];
        m.sm.sign = v[msg_width_default+1];
        m.sm.mag  = (mag[msg_width_default:msg_width_default-1] != '0) ?
                    sat_mag : mag[msg_width_default-2:0];
        return m;
    endfunction

endpackage

// ==== src/vpu_msg_update.sv ====
`timescale 1ns/1ns

module vpu_msg_update #(
    parameter int msg_width = vpu_msg_pkg::msg_width_default
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  vpu_addr_pkg::phase_e                        phase_i,
    input  logic [vpu_msg_pkg::lane_count*msg_width-1:0] lane_msg_i,
    input  logic [msg_width-1:0]                        chan_msg_i,
    output logic [vpu_msg_pkg::lane_count*msg_width-1:0] upd_msg_o,
    output logic                                        hard_dec_o
);

    import vpu_msg_pkg::*;
    import vpu_addr_pkg::*;

    // room for the channel value plus three lanes
    localparam int sum_width = msg_width + 2;

    msg_u                        lane_sm     [lane_count];
    msg_u                        chan_word;
    logic signed [msg_width-1:0] lane_int    [lane_count];
    logic signed [sum_width-1:0] total_sum;
    logic signed [sum_width-1:0] ext_sum_q   [lane_count];
    msg_u                        upd_q       [lane_count];
    logic                        hard_dec_q;

    always_comb begin
        chan_word.raw = chan_msg_i;
        total_sum     = sum_width'(signed'(chan_word.raw));
        for (int i = 0; i < lane_count; i++) begin
            lane_sm[i].raw = lane_msg_i[i*msg_width +: msg_width];
            lane_int[i]    = sm_to_int(lane_sm[i]);
            total_sum      = total_sum + sum_width'(lane_int[i]);
        end
    end

    // leave-one-out sums and hard decision
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hard_dec_q <= 1'b0;
            for (int i = 0; i < lane_count; i++) begin
                ext_sum_q[i] <= '0;
            end
        end else begin
            hard_dec_q <= total_sum[sum_width-1];
            for (int i = 0; i < lane_count; i++) begin
                ext_sum_q[i] <= total_sum - sum_width'(lane_int[i]);
            end
        end
    end

    // saturate back to sign-magnitude, var pass only
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < lane_count; i++) begin
                upd_q[i] <= '0;
            end
        end else if (phase_i == phase_var_update) begin
            for (int i = 0; i < lane_count; i++) begin
                upd_q[i] <= int_to_sat_sm(ext_sum_q[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            upd_msg_o[i*msg_width +: msg_width] = upd_q[i].raw;
        end
    end

    assign hard_dec_o = hard_dec_q;

endmodule

// ==== src/vpu_offset_tracker.sv ====
`timescale 1ns/1ns

module vpu_offset_tracker (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 start_i,
    input  logic                                 check_start_i,
    input  logic                                 var_start_i,
    input  logic                                 bank_wr_en_i,
    input  vpu_addr_pkg::phase_e                 phase_i,
    output logic [vpu_addr_pkg::addr_width-1:0]  bank_offset_o,
    output logic [vpu_addr_pkg::addr_width-1:0]  chan_offset_o
);

    import vpu_addr_pkg::*;

    logic [addr_width-1:0] wr_cnt_q;
    logic                  check_end_q;
    logic                  var_end_q;
    logic                  cnt_clear;
    logic                  last_write;

    assign cnt_clear = (check_start_i && (phase_i == phase_armed || phase_i == phase_var_update))
                    || (var_start_i && phase_i == phase_check);

    assign last_write = bank_wr_en_i && (wr_cnt_q == addr_wrap);

    // bank writes in the current pass
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt_q <= '0;
        end else if (cnt_clear) begin
            wr_cnt_q <= '0;
        end else if (bank_wr_en_i) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_end_q <= 1'b0;
            var_end_q   <= 1'b0;
        end else begin
            check_end_q <= last_write && (phase_i == phase_check);
            var_end_q   <= last_write && (phase_i == phase_var_update);
        end
    end

    // offsets rotate modulo 256
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bank_offset_o <= '0;
            chan_offset_o <= '0;
        end else if (start_i) begin
            bank_offset_o <= '0;
            chan_offset_o <= '0;
        end else if (check_end_q) begin
            bank_offset_o <= bank_offset_o + check_step;
        end else if (var_end_q) begin
            bank_offset_o <= bank_offset_o + bank_step;
            chan_offset_o <= chan_offset_o + chan_step;
        end
    end

endmodule

// ==== src/vpu_phase_ctrl.sv ====
`timescale 1ns/1ns

module vpu_phase_ctrl (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  logic                 check_start_i,
    input  logic                 var_start_i,
    output vpu_addr_pkg::phase_e phase_o,
    output logic                 var_wr_en_o
);

    import vpu_addr_pkg::*;

    phase_e                phase_q;
    phase_e                phase_next;
    logic [addr_width-1:0] var_cnt_q;
    logic                  var_wen_q;
    logic                  var_wen_d1_q;
    logic                  var_wen_d2_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase_q <= phase_idle;
        end else begin
            phase_q <= phase_next;
        end
    end

    always_comb begin
        phase_next = phase_q;
        case (phase_q)
            phase_idle: begin
                if (start_i)
                    phase_next = phase_armed;
            end
            phase_armed, phase_var_update: begin
                if (check_start_i)
                    phase_next = phase_check;
            end
            phase_check: begin
                if (var_start_i)
                    phase_next = phase_var_update;
            end
            default: phase_next = phase_idle;
        endcase
    end

    // cycles into the var pass
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            var_cnt_q <= '0;
        end else if (phase_q == phase_check && var_start_i) begin
            var_cnt_q <= '0;
        end else if (phase_q == phase_var_update) begin
            var_cnt_q <= var_cnt_q + 1'b1;
        end
    end

    // write window, then two stages for the memory read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            var_wen_q    <= 1'b0;
            var_wen_d1_q <= 1'b0;
            var_wen_d2_q <= 1'b0;
        end else begin
            var_wen_d1_q <= var_wen_q;
            var_wen_d2_q <= var_wen_d1_q;
            if (phase_q == phase_check && var_start_i)
                var_wen_q <= 1'b1;
            else if (phase_q == phase_var_update && (check_start_i || var_cnt_q == addr_wrap))
                var_wen_q <= 1'b0;
        end
    end

    assign phase_o     = phase_q;
    assign var_wr_en_o = var_wen_d2_q;

endmodule

// ==== src/vpu_top.sv ====
`timescale 1ns/1ns

module vpu_top #(
    parameter int msg_width = vpu_msg_pkg::msg_width_default
) (
    input  logic                                                        clk,
    input  logic                                                        reset_n,
    input  logic                                                        start_i,
    input  logic                                                        check_start_i,
    input  logic                                                        var_start_i,
    input  logic                                                        check_wr_en_i,
    input  logic [vpu_msg_pkg::lane_count*vpu_addr_pkg::addr_width-1:0] shift_i,
    input  logic [vpu_msg_pkg::lane_count*msg_width-1:0]                lane_msg_i,
    input  logic [msg_width-1:0]                                        chan_msg_i,
    output logic [vpu_msg_pkg::lane_count*vpu_addr_pkg::addr_width-1:0] bank_addr_o,
    output logic [vpu_addr_pkg::addr_width-1:0]                         chan_addr_o,
    output logic                                                        bank_wr_en_o,
    output logic [vpu_msg_pkg::lane_count*msg_width-1:0]                upd_msg_o,
    output logic                                                        hard_dec_o
);

    import vpu_addr_pkg::*;

    phase_e                phase;
    logic                  var_wr_en;
    logic [addr_width-1:0] bank_offset;
    logic [addr_width-1:0] chan_offset;

    vpu_phase_ctrl phase_ctrl_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .check_start_i (check_start_i),
        .var_start_i   (var_start_i),
        .phase_o       (phase),
        .var_wr_en_o   (var_wr_en)
    );

    vpu_offset_tracker offset_tracker_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .check_start_i (check_start_i),
        .var_start_i   (var_start_i),
        .bank_wr_en_i  (bank_wr_en_o),
        .phase_i       (phase),
        .bank_offset_o (bank_offset),
        .chan_offset_o (chan_offset)
    );

    vpu_addr_gen addr_gen_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .check_start_i (check_start_i),
        .var_start_i   (var_start_i),
        .check_wr_en_i (check_wr_en_i),
        .var_wr_en_i   (var_wr_en),
        .phase_i       (phase),
        .shift_i       (shift_i),
        .bank_offset_i (bank_offset),
        .chan_offset_i (chan_offset),
        .bank_addr_o   (bank_addr_o),
        .chan_addr_o   (chan_addr_o),
        .bank_wr_en_o  (bank_wr_en_o)
    );

    vpu_msg_update #(
        .msg_width (msg_width)
    ) msg_update_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .phase_i    (phase),
        .lane_msg_i (lane_msg_i),
        .chan_msg_i (chan_msg_i),
        .upd_msg_o  (upd_msg_o),
        .hard_dec_o (hard_dec_o)
    );

endmodule

// ==== tb/vpu_properties.sv ====
`timescale 1ns/1ns

module vpu_properties (
    input logic                 clk,
    input logic                 reset_n,
    input vpu_addr_pkg::phase_e phase_i,
    input logic                 bank_wr_en_i
);

    import vpu_addr_pkg::*;

    int fail_count = 0;

    property wr_en_low_in_reset;
        @(posedge clk) !reset_n |-> !bank_wr_en_i;
    endproperty

    property phase_one_hot;
        @(posedge clk) disable iff (!reset_n) $onehot(phase_i);
    endproperty

    // strobe is registered from the phase, so idle now means no write next cycle
    property no_write_from_idle;
        @(posedge clk) disable iff (!reset_n) (phase_i == phase_idle) |=> !bank_wr_en_i;
    endproperty

    wr_en_low_in_reset_a: assert property (wr_en_low_in_reset)
        else begin
            fail_count++;
            $error("bank write strobe high while reset is asserted");
        end
    phase_one_hot_a: assert property (phase_one_hot)
        else begin
            fail_count++;
            $error("phase register is not one-hot");
        end
    no_write_from_idle_a: assert property (no_write_from_idle)
        else begin
            fail_count++;
            $error("bank write strobe rose out of the idle phase");
        end

endmodule

// ==== tb/vpu_tb.sv ====
`timescale 1ns/1ns

module vpu_tb;

    import vpu_msg_pkg::*;
    import vpu_addr_pkg::*;

    localparam int msg_w      = msg_width_default;
    localparam int lane_bits  = lane_count * msg_w;
    localparam int shift_bits = lane_count * addr_width;

    logic                  clk;
    logic                  reset_n;
    logic                  start_i;
    logic                  check_start_i;
    logic                  var_start_i;
    logic                  check_wr_en_i;
    logic [shift_bits-1:0] shift_i;
    logic [lane_bits-1:0]  lane_msg_i;
    logic [msg_w-1:0]      chan_msg_i;
    logic [shift_bits-1:0] bank_addr_o;
    logic [addr_width-1:0] chan_addr_o;
    logic                  bank_wr_en_o;
    logic [lane_bits-1:0]  upd_msg_o;
    logic                  hard_dec_o;

    logic [31:0]           lfsr_q = 32'h9b8b;
    int                    checks = 0;
    int                    errors = 0;
    int                    upd_errs = 0;
    int                    dec_errs = 0;
    logic                  cmp_on;
    logic [lane_bits-1:0]  lane_hist [2];
    logic [msg_w-1:0]      chan_hist [2];
    int                    hist_depth = 0;

    vpu_top #(.msg_width(msg_w)) vpu_top_inst (.*);

    bind vpu_top vpu_properties properties_inst (
        .clk(clk), .reset_n(reset_n), .phase_i(phase), .bank_wr_en_i(bank_wr_en_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    function automatic int check_value(input string name, input logic [31:0] got,
                                       input logic [31:0] expected);
        int bad;
        bad = 0;
        checks++;
        assert (got == expected) else begin
            errors++;
            bad = 1;
            $display("Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
        return bad;
    endfunction

    // each lane plus a common step modulo the bank size
    function automatic logic [shift_bits-1:0] addr_lanes(input logic [shift_bits-1:0] base,
                                                         input logic [addr_width-1:0] step);
        logic [shift_bits-1:0] r;
        for (int k = 0; k < lane_count; k++)
            r[k*addr_width +: addr_width] = base[k*addr_width +: addr_width] + step;
        return r;
    endfunction

    // updated lanes with the hard decision in the top bit
    function automatic logic [lane_bits:0] ref_update(input logic [lane_bits-1:0] lanes,
                                                      input logic [msg_w-1:0]     chan);
        logic [lane_bits:0] r;
        int                 v [lane_count];
        int                 total;
        int                 ext;
        int                 mag;
        total = int'($signed(chan));
        for (int i = 0; i < lane_count; i++) begin
            mag   = int'(lanes[i*msg_w +: msg_w-1]);
            v[i]  = lanes[i*msg_w + msg_w - 1] ? -mag : mag;
            total = total + v[i];
        end
        for (int i = 0; i < lane_count; i++) begin
            ext = total - v[i];
            mag = (ext < 0) ? -ext : ext;
            if (mag > (1 << (msg_w - 1)) - 1)
                mag = (1 << (msg_w - 1)) - 1;
            r[i*msg_w +: msg_w] = {ext < 0, mag[msg_w-2:0]};
        end
        r[lane_bits] = total < 0;
        return r;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // 0 start, 1 check start, 2 var start
    task automatic pulse(input int which);
        @(posedge clk);
        start_i       <= (which == 0);
        check_start_i <= (which == 1);
        var_start_i   <= (which == 2);
        @(posedge clk);
        start_i       <= 1'b0;
        check_start_i <= 1'b0;
        var_start_i   <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errs);
        $display("test %s finished with %0d errors", name, errs);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // hard decision one cycle and lanes two cycles behind the inputs
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare_proc
        logic [lane_bits:0] expected;
        if (!cmp_on) begin
            hist_depth = 0;
        end else begin
            if (hist_depth >= 1) begin
                expected = ref_update(lane_hist[0], chan_hist[0]);
                dec_errs += check_value("hard_dec_o", 32'(hard_dec_o),
                                        32'(expected[lane_bits]));
            end
            if (hist_depth >= 2) begin
                expected = ref_update(lane_hist[1], chan_hist[1]);
                upd_errs += check_value("upd_msg_o", 32'(upd_msg_o),
                                        32'(expected[lane_bits-1:0]));
            end
            lane_hist[1] = lane_hist[0];
            chan_hist[1] = chan_hist[0];
            lane_hist[0] = lane_msg_i;
            chan_hist[0] = chan_msg_i;
            if (hist_depth < 2)
                hist_depth++;
        end
    end

    initial begin
        logic [shift_bits-1:0] shift;
        logic                  prev_wen;
        int                    err0;
        int                    cyc;
        int                    seen;
        int                    driven;

        reset_n       = 1'b1;
        start_i       = 1'b0;
        check_start_i = 1'b0;
        var_start_i   = 1'b0;
        check_wr_en_i = 1'b0;
        shift_i       = '0;
        lane_msg_i    = '0;
        chan_msg_i    = '0;
        cmp_on        = 1'b0;
        #1 reset_n = 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        err0 = errors;
        void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'd0));
        void'(check_value("chan_addr_o", 32'(chan_addr_o), 32'd0));
        void'(check_value("bank_wr_en_o", 32'(bank_wr_en_o), 32'd0));
        void'(check_value("upd_msg_o", 32'(upd_msg_o), 32'd0));
        void'(check_value("hard_dec_o", 32'(hard_dec_o), 32'd0));

        // stray check strobe in idle must stay off the banks
        @(posedge clk);
        check_wr_en_i <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            void'(check_value("bank_wr_en_o", 32'(bank_wr_en_o), 32'd0));
        end
        @(posedge clk);
        check_wr_en_i <= 1'b0;
        report_test("reset", errors - err0);

        // lane 2 starts near the top so the sweep wraps
        err0 = errors;
        pulse(0);
        shift = {8'hfd, 16'(take_bits(16))};
        shift_i <= shift;
        pulse(1);
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'(addr_lanes(shift, 8'(k)))));
        end
        report_test("check start", errors - err0);

        err0     = errors;
        prev_wen = 1'b0;
        seen     = 0;
        driven   = 0;
        cyc      = 0;
        while (seen < 256 && cyc < 2000) begin
            @(posedge clk);
            if (driven < 256 && take_bits(1) != 0) begin
                check_wr_en_i <= 1'b1;
                driven++;
            end else begin
                check_wr_en_i <= 1'b0;
            end
            @(negedge clk);
            void'(check_value("bank_wr_en_o", 32'(bank_wr_en_o), 32'(prev_wen)));
            if (bank_wr_en_o)
                seen++;
            prev_wen = check_wr_en_i;
            cyc++;
        end
        if (seen < 256)
            abort_on_timeout("check pass never reached 256 bank writes");
        repeat (3) @(posedge clk);
        shift = shift_bits'(take_bits(shift_bits));
        shift_i <= shift;
        pulse(2);
        pulse(1);
        @(negedge clk);
        // check pass moved the bank offset by 5
        void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'(addr_lanes(shift, 8'd5))));
        report_test("check pass", errors - err0);

        err0 = errors;
        pulse(2);
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc == 1) begin
                void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'({lane_count{8'd5}})));
                void'(check_value("chan_addr_o", 32'(chan_addr_o), 32'd0));
            end
        end while (!bank_wr_en_o && cyc < 20);
        if (!bank_wr_en_o)
            abort_on_timeout("var pass write strobe never rose");
        void'(check_value("bank_wr_en_o rise cycle", 32'(cyc), 32'd4));
        cyc = 0;
        while (bank_wr_en_o && cyc < 300) begin
            cyc++;
            @(negedge clk);
        end
        if (bank_wr_en_o)
            abort_on_timeout("var pass write strobe never fell");
        void'(check_value("bank_wr_en_o high cycles", 32'(cyc), 32'd256));
        repeat (3) @(posedge clk);
        shift = shift_bits'(take_bits(shift_bits));
        shift_i <= shift;
        pulse(1);
        @(negedge clk);
        void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'(addr_lanes(shift, 8'd8))));
        pulse(2);
        @(negedge clk);
        void'(check_value("bank_addr_o", 32'(bank_addr_o), 32'({lane_count{8'd8}})));
        void'(check_value("chan_addr_o", 32'(chan_addr_o), 32'd2));
        report_test("var pass", errors - err0);

        // messages while the second var pass runs
        for (int n = 0; n < 300; n++) begin
            @(posedge clk);
            if (n % 8 == 3) begin
                lane_msg_i <= {lane_count{6'h3f}};
                chan_msg_i <= 6'h20;
            end else if (n % 8 == 7) begin
                lane_msg_i <= {lane_count{6'h1f}};
                chan_msg_i <= 6'h1f;
            end else begin
                lane_msg_i <= lane_bits'(take_bits(lane_bits));
                chan_msg_i <= msg_w'(take_bits(msg_w));
            end
            cmp_on = 1'b1;
        end
        repeat (3) @(posedge clk);
        cmp_on = 1'b0;
        report_test("updated messages", upd_errs);
        report_test("hard decision", dec_errs);

        errors += vpu_top_inst.properties_inst.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
